//--- fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    localparam int ADDR_W         = 32;
    localparam int INST_W         = 32;
    localparam int BEAT_W         = 64;
    localparam int LINE_W         = 256;
    localparam int BEATS_PER_LINE = 4;
    localparam int WORDS_PER_LINE = 8;
    localparam int LINE_OFFSET_W  = 5;   // byte offset inside a line

    localparam logic [ADDR_W-1:0] RESET_PC = 32'h1eceb000;

    localparam int IQ_DEPTH = 16;

    localparam int LINE_TAG_W = ADDR_W - LINE_OFFSET_W;
    localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);
    localparam int BEAT_CNT_W = $clog2(BEATS_PER_LINE);
    localparam int IQ_PTR_W   = $clog2(IQ_DEPTH);
    localparam int IQ_CNT_W   = $clog2(IQ_DEPTH + 1);

    localparam logic [BEAT_CNT_W-1:0] LAST_BEAT = BEAT_CNT_W'(BEATS_PER_LINE - 1);
    localparam logic [IQ_CNT_W-1:0]   IQ_FULL   = IQ_CNT_W'(IQ_DEPTH);

    // burst adapter states
    localparam int                BA_STATE_W = 2;
    localparam logic [BA_STATE_W-1:0] BA_IDLE    = 2'd0;
    localparam logic [BA_STATE_W-1:0] BA_REQ     = 2'd1;
    localparam logic [BA_STATE_W-1:0] BA_COLLECT = 2'd2;
    localparam logic [BA_STATE_W-1:0] BA_DONE    = 2'd3;

    // a line filled by beats and read by words with beat 0 and words 0-1 at the low end
    typedef union packed {
        logic [BEATS_PER_LINE-1:0][BEAT_W-1:0] beat;
        logic [WORDS_PER_LINE-1:0][INST_W-1:0] word;
    } fetch_line_t;

endpackage

`default_nettype wire

//--- fetch_pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         space_i,
    input  logic                         resp_i,
    output logic                         req_o,
    output logic [fetch_pkg::ADDR_W-1:0] pc_o
);

    logic [fetch_pkg::ADDR_W-1:0] pc_q;
    logic                         waiting_q;   // one word request in flight

    // queue room was checked here, so the in-flight word always has a slot
    assign req_o = space_i && !waiting_q;
    assign pc_o  = pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q      <= fetch_pkg::RESET_PC;
            waiting_q <= 1'b0;
        end else begin
            if (req_o) begin
                waiting_q <= 1'b1;
            end
            if (resp_i) begin
                waiting_q <= 1'b0;
                pc_q      <= pc_q + 32'd4;   // sequential fetch only
            end
        end
    end

    // the line buffer only answers an issued request
    assert property (@(posedge clk) disable iff (rst)
        resp_i |-> waiting_q)
        else $error("fetch_pc_gen: response without a request");

endmodule

`default_nettype wire

//--- line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module line_buffer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req_i,
    input  logic [fetch_pkg::ADDR_W-1:0] addr_i,
    output logic                         resp_o,
    output logic [fetch_pkg::INST_W-1:0] rdata_o,
    output logic                         line_req_o,
    output logic [fetch_pkg::ADDR_W-1:0] line_addr_o,
    input  logic                         line_valid_i,
    input  fetch_pkg::fetch_line_t       line_i
);

    fetch_pkg::fetch_line_t           line_q;
    logic [fetch_pkg::LINE_TAG_W-1:0] tag_q;
    logic                             valid_q;
    logic                             line_req_q;
    logic                             resp_q;

    logic [fetch_pkg::LINE_TAG_W-1:0] req_tag;
    logic [fetch_pkg::WORD_SEL_W-1:0] word_sel;
    logic                             hit;
    logic                             miss;
    logic                             fill;

    assign req_tag  = addr_i[fetch_pkg::ADDR_W-1:fetch_pkg::LINE_OFFSET_W];
    assign word_sel = addr_i[fetch_pkg::LINE_OFFSET_W-1:2];
    assign hit      = valid_q && (tag_q == req_tag);
    assign miss     = req_i && !line_req_q && !hit;
    assign fill     = line_req_q && line_valid_i;

    assign resp_o      = resp_q;
    assign rdata_o     = line_q.word[word_sel];   // addr_i is held until resp_o
    assign line_req_o  = line_req_q;
    assign line_addr_o = {tag_q, {fetch_pkg::LINE_OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q    <= 1'b0;
            line_req_q <= 1'b0;
            resp_q     <= 1'b0;
        end else begin
            resp_q <= 1'b0;
            if (line_req_q) begin
                if (line_valid_i) begin
                    line_req_q <= 1'b0;
                    valid_q    <= 1'b1;
                    resp_q     <= 1'b1;   // answer the cycle after the refill lands
                end
            end else if (req_i) begin
                if (hit) begin
                    resp_q <= 1'b1;
                end else begin
                    line_req_q <= 1'b1;
                    valid_q    <= 1'b0;   // old line is replaced
                end
            end
        end
    end

    // tag doubles as the pending refill address while the line is invalid
    always_ff @(posedge clk) begin
        if (miss) begin
            tag_q <= req_tag;
        end
        if (fill) begin
            line_q <= line_i;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        line_valid_i |-> line_req_o)
        else $error("line_buffer: refill returned without a pending request");

endmodule

`default_nettype wire

//--- burst_adapter.sv
`timescale 1ns/1ps
`default_nettype none

module burst_adapter (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         line_req_i,
    input  logic [fetch_pkg::ADDR_W-1:0] line_addr_i,
    output logic [fetch_pkg::ADDR_W-1:0] bmem_addr_o,
    output logic                         bmem_read_o,
    input  logic                         bmem_ready_i,
    input  logic [fetch_pkg::ADDR_W-1:0] bmem_raddr_i,
    input  logic [fetch_pkg::BEAT_W-1:0] bmem_rdata_i,
    input  logic                         bmem_rvalid_i,
    output logic                         line_valid_o,
    output fetch_pkg::fetch_line_t       line_o
);

    logic [fetch_pkg::BA_STATE_W-1:0] state_q;
    logic [fetch_pkg::BEAT_CNT_W-1:0] beat_cnt_q;
    logic [fetch_pkg::ADDR_W-1:0]     addr_q;
    fetch_pkg::fetch_line_t           line_q;

    assign bmem_read_o  = (state_q == fetch_pkg::BA_REQ);   // held until accepted
    assign bmem_addr_o  = addr_q;
    assign line_valid_o = (state_q == fetch_pkg::BA_DONE);
    assign line_o       = line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= fetch_pkg::BA_IDLE;
            beat_cnt_q <= '0;
        end else begin
            case (state_q)
                fetch_pkg::BA_IDLE: if (line_req_i) state_q <= fetch_pkg::BA_REQ;
                fetch_pkg::BA_REQ: begin
                    if (bmem_ready_i) begin
                        state_q    <= fetch_pkg::BA_COLLECT;
                        beat_cnt_q <= '0;
                    end
                end
                fetch_pkg::BA_COLLECT: begin
                    if (bmem_rvalid_i) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (beat_cnt_q == fetch_pkg::LAST_BEAT) state_q <= fetch_pkg::BA_DONE;
                    end
                end
                default: state_q <= fetch_pkg::BA_IDLE;   // done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == fetch_pkg::BA_IDLE && line_req_i) begin
            addr_q <= line_addr_i;
        end
        if (state_q == fetch_pkg::BA_COLLECT && bmem_rvalid_i) begin
            line_q.beat[beat_cnt_q] <= bmem_rdata_i;   // beats return in address order
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        bmem_rvalid_i |-> (bmem_raddr_i == addr_q))
        else $error("burst_adapter: beat for a line that was not requested");

endmodule

`default_nettype wire

//--- inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

module inst_queue (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wr_i,
    input  logic [fetch_pkg::ADDR_W-1:0] pc_i,
    input  logic [fetch_pkg::INST_W-1:0] inst_i,
    output logic                         space_o,
    output logic                         fetch_valid_o,
    output logic [fetch_pkg::ADDR_W-1:0] fetch_pc_o,
    output logic [fetch_pkg::INST_W-1:0] fetch_inst_o,
    input  logic                         fetch_ready_i
);

    logic [fetch_pkg::ADDR_W-1:0] pc_mem   [fetch_pkg::IQ_DEPTH];
    logic [fetch_pkg::INST_W-1:0] inst_mem [fetch_pkg::IQ_DEPTH];

    logic [fetch_pkg::IQ_PTR_W-1:0] wr_ptr_q;
    logic [fetch_pkg::IQ_PTR_W-1:0] rd_ptr_q;
    logic [fetch_pkg::IQ_CNT_W-1:0] count_q;
    logic                           rd;

    assign rd            = fetch_valid_o && fetch_ready_i;
    assign space_o       = (count_q != fetch_pkg::IQ_FULL);
    assign fetch_valid_o = (count_q != '0);
    assign fetch_pc_o    = pc_mem[rd_ptr_q];     // oldest pair
    assign fetch_inst_o  = inst_mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;   // wraps by itself at a power-of-two depth
            end
            if (rd) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({wr_i, rd})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i) begin
            pc_mem[wr_ptr_q]   <= pc_i;
            inst_mem[wr_ptr_q] <= inst_i;
        end
    end

    // the requester checks space before issuing, so a write never meets a full queue
    assert property (@(posedge clk) disable iff (rst)
        wr_i |-> (count_q != fetch_pkg::IQ_FULL))
        else $error("inst_queue: write while full");

endmodule

`default_nettype wire

//--- fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  logic                         clk,
    input  logic                         rst,

    output logic [fetch_pkg::ADDR_W-1:0] bmem_addr_o,
    output logic                         bmem_read_o,
    input  logic                         bmem_ready_i,
    input  logic [fetch_pkg::ADDR_W-1:0] bmem_raddr_i,
    input  logic [fetch_pkg::BEAT_W-1:0] bmem_rdata_i,
    input  logic                         bmem_rvalid_i,

    output logic                         fetch_valid_o,
    output logic [fetch_pkg::ADDR_W-1:0] fetch_pc_o,
    output logic [fetch_pkg::INST_W-1:0] fetch_inst_o,
    input  logic                         fetch_ready_i
);

    logic                         word_req;
    logic [fetch_pkg::ADDR_W-1:0] word_pc;
    logic                         word_resp;
    logic [fetch_pkg::INST_W-1:0] word_rdata;
    logic                         iq_space;

    logic                         line_req;
    logic [fetch_pkg::ADDR_W-1:0] line_addr;
    logic                         line_valid;
    fetch_pkg::fetch_line_t       line_data;

    fetch_pc_gen pc_gen_i (
        .clk     (clk),
        .rst     (rst),
        .space_i (iq_space),
        .resp_i  (word_resp),
        .req_o   (word_req),
        .pc_o    (word_pc)
    );

    line_buffer line_buffer_i (
        .clk          (clk),
        .rst          (rst),
        .req_i        (word_req),
        .addr_i       (word_pc),
        .resp_o       (word_resp),
        .rdata_o      (word_rdata),
        .line_req_o   (line_req),
        .line_addr_o  (line_addr),
        .line_valid_i (line_valid),
        .line_i       (line_data)
    );

    burst_adapter burst_adapter_i (
        .clk           (clk),
        .rst           (rst),
        .line_req_i    (line_req),
        .line_addr_i   (line_addr),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .line_valid_o  (line_valid),
        .line_o        (line_data)
    );

    inst_queue inst_queue_i (
        .clk           (clk),
        .rst           (rst),
        .wr_i          (word_resp),     // every answered word is queued
        .pc_i          (word_pc),
        .inst_i        (word_rdata),
        .space_o       (iq_space),
        .fetch_valid_o (fetch_valid_o),
        .fetch_pc_o    (fetch_pc_o),
        .fetch_inst_o  (fetch_inst_o),
        .fetch_ready_i (fetch_ready_i)
    );

endmodule

`default_nettype wire

//--- tb_bmem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bmem #(
    parameter logic [fetch_pkg::ADDR_W-1:0] PATTERN = '0,
    parameter int                           SEED    = 0
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [fetch_pkg::ADDR_W-1:0] bmem_addr_i,
    input  logic                         bmem_read_i,
    output logic                         bmem_ready_o,
    output logic [fetch_pkg::ADDR_W-1:0] bmem_raddr_o,
    output logic [fetch_pkg::BEAT_W-1:0] bmem_rdata_o,
    output logic                         bmem_rvalid_o
);

    integer seed;

    // beat b of a line holds two words with the lower address in the low half
    function automatic logic [fetch_pkg::BEAT_W-1:0] beat_data(
        input logic [fetch_pkg::ADDR_W-1:0] line_addr,
        input int                           beat
    );
        logic [fetch_pkg::ADDR_W-1:0] lo_addr;
        lo_addr = line_addr + fetch_pkg::ADDR_W'(8 * beat);
        return {(lo_addr + 32'd4) ^ PATTERN, lo_addr ^ PATTERN};
    endfunction

    initial begin
        int                           gap;
        logic [fetch_pkg::ADDR_W-1:0] addr;
        seed          = SEED;
        bmem_ready_o  = 1'b0;
        bmem_raddr_o  = '0;
        bmem_rdata_o  = '0;
        bmem_rvalid_o = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && bmem_read_i) begin
                gap = $unsigned($random(seed)) % 4;   // acceptance delay
                repeat (gap) @(negedge clk);
                bmem_ready_o = 1'b1;
                addr         = bmem_addr_i;
                @(negedge clk);
                bmem_ready_o = 1'b0;
                for (int b = 0; b < fetch_pkg::BEATS_PER_LINE; b++) begin
                    gap = $unsigned($random(seed)) % 3;   // gap before each beat
                    repeat (gap) @(negedge clk);
                    bmem_rvalid_o = 1'b1;
                    bmem_raddr_o  = addr;
                    bmem_rdata_o  = beat_data(addr, b);
                    @(negedge clk);
                    bmem_rvalid_o = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch;

    localparam logic [fetch_pkg::ADDR_W-1:0] MEM_PATTERN = 32'h5a3c96e1;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int MIN_TRANSFERS  = 320;
    localparam int READY_PCT      = 60;
    localparam int QUIET_CYCLES   = 100;

    logic                         clk;
    logic                         rst;
    logic [fetch_pkg::ADDR_W-1:0] bmem_addr;
    logic                         bmem_read;
    logic                         bmem_ready;
    logic [fetch_pkg::ADDR_W-1:0] bmem_raddr;
    logic [fetch_pkg::BEAT_W-1:0] bmem_rdata;
    logic                         bmem_rvalid;
    logic                         fetch_valid;
    logic [fetch_pkg::ADDR_W-1:0] fetch_pc;
    logic [fetch_pkg::INST_W-1:0] fetch_inst;
    logic                         fetch_ready;

    integer                       seed;
    int                           errors;
    int                           checks;
    int                           transfers;
    int                           reads;
    logic [fetch_pkg::ADDR_W-1:0] exp_pc;
    logic [fetch_pkg::ADDR_W-1:0] next_read_line;
    logic [fetch_pkg::ADDR_W-1:0] held_pc;
    logic [fetch_pkg::INST_W-1:0] held_inst;
    logic                         stall_q;
    logic                         timed_out;
    bit                           line_seen [logic [fetch_pkg::ADDR_W-1:0]];

    fetch_top dut (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready),
        .bmem_raddr_i  (bmem_raddr),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid),
        .fetch_valid_o (fetch_valid),
        .fetch_pc_o    (fetch_pc),
        .fetch_inst_o  (fetch_inst),
        .fetch_ready_i (fetch_ready)
    );

    tb_bmem #(.PATTERN(MEM_PATTERN), .SEED(32'h8023)) bmem_i (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_i   (bmem_addr),
        .bmem_read_i   (bmem_read),
        .bmem_ready_o  (bmem_ready),
        .bmem_raddr_o  (bmem_raddr),
        .bmem_rdata_o  (bmem_rdata),
        .bmem_rvalid_o (bmem_rvalid)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [fetch_pkg::ADDR_W-1:0] line_of(
        input logic [fetch_pkg::ADDR_W-1:0] a
    );
        return {a[fetch_pkg::ADDR_W-1:fetch_pkg::LINE_OFFSET_W], {fetch_pkg::LINE_OFFSET_W{1'b0}}};
    endfunction

    task automatic check_addr(input string name, input logic [fetch_pkg::ADDR_W-1:0] expected,
                              input logic [fetch_pkg::ADDR_W-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_inst(input string name, input logic [fetch_pkg::INST_W-1:0] expected,
                              input logic [fetch_pkg::INST_W-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %0t %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("%0t: %s", $time, what);
    endtask

    // memory reads, held outputs and transfers seen with their pre-edge values
    always @(posedge clk) begin
        if (!rst) begin
            if (bmem_read && bmem_ready) begin
                check_addr("bmem_addr_o", next_read_line, bmem_addr);
                line_seen[bmem_addr] = 1'b1;
                next_read_line = next_read_line + (1 << fetch_pkg::LINE_OFFSET_W);
                reads++;
            end
            if (stall_q) begin
                check_flag("fetch_valid_o", 1'b1, fetch_valid);
                check_addr("fetch_pc_o", held_pc, fetch_pc);
                check_inst("fetch_inst_o", held_inst, fetch_inst);
            end
            if (fetch_valid && fetch_ready) begin
                if (!line_seen.exists(line_of(exp_pc)))
                    note_failure("a pair was delivered before its line was read from memory");
                check_addr("fetch_pc_o", exp_pc, fetch_pc);
                check_inst("fetch_inst_o", exp_pc ^ MEM_PATTERN, fetch_inst);
                exp_pc = exp_pc + 32'd4;
                transfers++;
            end
            stall_q   = fetch_valid && !fetch_ready;
            held_pc   = fetch_pc;
            held_inst = fetch_inst;
        end
    end

    initial begin
        int                           idle;
        int                           last_transfers;
        int                           expected_reads;
        logic [fetch_pkg::ADDR_W-1:0] last_pc;
        seed           = 32'h8023;
        errors         = 0;
        checks         = 0;
        transfers      = 0;
        reads          = 0;
        exp_pc         = fetch_pkg::RESET_PC;
        next_read_line = line_of(fetch_pkg::RESET_PC);
        stall_q        = 1'b0;
        held_pc        = '0;
        held_inst      = '0;
        timed_out      = 1'b0;
        rst            = 1'b1;
        fetch_ready    = 1'b0;

        repeat (8) @(posedge clk);
        @(negedge clk);
        check_flag("fetch_valid_o", 1'b0, fetch_valid);
        check_flag("bmem_read_o", 1'b0, bmem_read);
        rst = 1'b0;

        // random consumer back-pressure
        idle           = 0;
        last_transfers = 0;
        while (transfers < MIN_TRANSFERS && !timed_out) begin
            @(negedge clk);
            fetch_ready = ($unsigned($random(seed)) % 100) < READY_PCT;
            if (transfers != last_transfers) begin
                idle           = 0;
                last_transfers = transfers;
            end else begin
                idle++;
            end
            if (idle > TIMEOUT_CYCLES) begin
                note_failure("timeout, no instruction was transferred for 2000 cycles");
                timed_out = 1'b1;
            end
        end

        // stop consuming so the queue fills and fetch stalls
        if (!timed_out) begin
            @(negedge clk);
            fetch_ready = 1'b0;
            last_pc     = exp_pc + 32'd4 * (fetch_pkg::IQ_DEPTH - 1);
            idle        = 0;
            while (!line_seen.exists(line_of(last_pc)) && !timed_out) begin
                @(negedge clk);
                idle++;
                if (idle > TIMEOUT_CYCLES) begin
                    note_failure("timeout waiting for the read that fills the queue");
                    timed_out = 1'b1;
                end
            end
        end

        if (!timed_out) begin
            repeat (QUIET_CYCLES) @(negedge clk);   // any extra read would show up here
            check_flag("fetch_valid_o", 1'b1, fetch_valid);
            expected_reads = int'((line_of(last_pc) - line_of(fetch_pkg::RESET_PC))
                                  >> fetch_pkg::LINE_OFFSET_W) + 1;
            if (reads != expected_reads)
                note_failure($sformatf("%0d memory reads for %0d lines reached",
                                       reads, expected_reads));
        end

        $display("transfers %0d reads %0d checks %0d errors %0d",
                 transfers, reads, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fetch.f
fetch_pkg.sv
fetch_pc_gen.sv
line_buffer.sv
burst_adapter.sv
inst_queue.sv
fetch_top.sv
tb_bmem.sv
tb_fetch.sv

//--- run.sh
#!/bin/sh
# build the fetch testbench with Verilator, run it, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch \
    -f fetch.f -o tb_fetch > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_fetch > sim.log 2>&1

grep -q "^No errors$" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL, see sim.log"; exit 1; }
